// File: src.f
verilog/mgmt_pkg.sv
verilog/mgmt_bus_if.sv
verilog/mgmt_decode.sv
verilog/relay_ctrl.sv
verilog/front_panel_ctrl.sv
verilog/muxsel_regs.sv
verilog/read_return.sv
verilog/mgmt_top.sv
tests/mgmt_asserts.sv
tests/mgmt_tb.sv

// File: tests/mgmt_asserts.sv
`timescale 1ns/1ps

module mgmt_asserts
	import mgmt_pkg::*;
#(
	parameter int NUM_MUX_CHANNELS = 12
)(
	input logic clk,
	input logic rst_n,
	input logic rd_en,
	input logic rd_valid,
	input logic relay_en,
	input logic front_shift_en,
	input logic front_cs_n,
	input muxsel_t [NUM_MUX_CHANNELS-1:0] muxsel
);

	////////////////////////////////////////////////////////////
	// Read latency, one decode stage plus one return stage

	read_latency: assert property (@(posedge clk) disable iff (!rst_n)
		rd_en |-> ##2 rd_valid)
		else $error("rd_valid missing two cycles after rd_en");

	no_stray_valid: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid |-> $past(rd_en, 2))
		else $error("rd_valid without a read two cycles earlier");

	////////////////////////////////////////////////////////////
	// Command pulses

	relay_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		relay_en |=> !relay_en)
		else $error("relay_en held longer than one cycle");

	shift_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		front_shift_en |=> !front_shift_en)
		else $error("front_shift_en held longer than one cycle");

	// Outputs idle right after any reset cycle
	reset_state: assert property (@(posedge clk)
		!rst_n |=> (!rd_valid && !relay_en && !front_shift_en && front_cs_n && muxsel == '0))
		else $error("outputs not in reset state after reset");

endmodule

bind mgmt_top mgmt_asserts #(
	.NUM_MUX_CHANNELS(NUM_MUX_CHANNELS)
) i_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.rd_en(rd_en),
	.rd_valid(rd_valid),
	.relay_en(relay_en),
	.front_shift_en(front_shift_en),
	.front_cs_n(front_cs_n),
	.muxsel(muxsel)
);

// File: tests/mgmt_tb.sv
`timescale 1ns/1ps

module mgmt_tb
	import mgmt_pkg::*;
();

	localparam int NUM_MUX = 12;

	// Rough cycle cost of each test
	localparam int RESET_CYCLES = 7;
	localparam int SENSOR_CYCLES = 30;
	localparam int MUX_CYCLES = 32;
	localparam int RELAY_CYCLES = 72;
	localparam int FRONT_CYCLES = 70;
	localparam int TIMEOUT_CYCLES =
		2 * (RESET_CYCLES + SENSOR_CYCLES + MUX_CYCLES + RELAY_CYCLES + FRONT_CYCLES);

	logic clk;
	logic rst_n;
	logic rd_en;
	reg_addr_t rd_addr;
	logic rd_valid;
	reg_data_t rd_data;
	logic wr_en;
	reg_addr_t wr_addr;
	reg_data_t wr_data;
	sensor_val_t fan0_rpm;
	sensor_val_t fan1_rpm;
	sensor_val_t die_temp;
	sensor_val_t volt_core;
	sensor_val_t volt_ram;
	sensor_val_t volt_aux;
	logic [TRIG_PORTS-1:0] trig_in_led;
	logic [TRIG_PORTS-1:0] trig_out_led;
	logic relay_en;
	logic relay_dir;
	relay_chan_t relay_channel;
	logic relay_done;
	logic front_shift_en;
	reg_data_t front_shift_data;
	logic front_shift_done;
	logic front_cs_n;
	muxsel_t [NUM_MUX-1:0] muxsel;

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	logic [31:0] lcg_state = 32'h3294_0b29;

	// Relay directions as commanded, 1 = input
	logic [RELAY_CHANNELS-1:0] relay_model = '0;

	mgmt_top #(
		.NUM_MUX_CHANNELS(NUM_MUX)
	) i_dut (
		.clk(clk), .rst_n(rst_n),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_valid(rd_valid), .rd_data(rd_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.fan0_rpm(fan0_rpm), .fan1_rpm(fan1_rpm), .die_temp(die_temp),
		.volt_core(volt_core), .volt_ram(volt_ram), .volt_aux(volt_aux),
		.trig_in_led(trig_in_led), .trig_out_led(trig_out_led),
		.relay_en(relay_en), .relay_dir(relay_dir), .relay_channel(relay_channel),
		.relay_done(relay_done),
		.front_shift_en(front_shift_en), .front_shift_data(front_shift_data),
		.front_shift_done(front_shift_done), .front_cs_n(front_cs_n),
		.muxsel(muxsel)
	);

	initial begin
		clk = 1'b0;
	end

	always #50 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests still running after %0d clock cycles", cycle_count);
			$display("Test FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers

	// LCG, upper bits are the useful ones
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t ns: %s, got %0h, expected %0h",
				$time, what, actual, expected);
		end
	endtask

	// Expected panel image from the LED rule
	function automatic led_state_t panel_image(input logic [TRIG_PORTS-1:0] in_leds,
			input logic [TRIG_PORTS-1:0] out_leds, input logic [RELAY_CHANNELS-1:0] relays);
		logic [TRIG_PORTS-1:0] reversed;
		for (int i = 0; i < TRIG_PORTS; i++) begin
			reversed[i] = in_leds[TRIG_PORTS-1-i];
		end
		return {reversed, out_leds & ~{relays, 8'h00}};
	endfunction

	// Strobe held for one rising edge, returns on the next falling edge
	task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
		@(negedge clk);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	// Response expected exactly two edges after the strobe
	task automatic read_check(input reg_addr_t addr, input reg_data_t expected,
			input string what);
		@(negedge clk);
		rd_en = 1'b1;
		rd_addr = addr;
		@(negedge clk);
		rd_en = 1'b0;
		check_value(32'(rd_valid), 32'd0, {what, ": early rd_valid"});
		@(negedge clk);
		check_value(32'(rd_valid), 32'd1, {what, ": rd_valid"});
		check_value(32'(rd_data), 32'(expected), {what, ": rd_data"});
	endtask

	////////////////////////////////////////////////////////////
	// Tests

	task automatic test_reset_state();
		@(negedge clk);
		check_value(32'(rd_valid), 32'd0, "rd_valid after reset");
		check_value(32'(rd_data), 32'd0, "rd_data after reset");
		check_value(32'(relay_en), 32'd0, "relay_en after reset");
		check_value(32'(relay_dir), 32'd0, "relay_dir after reset");
		check_value(32'(relay_channel), 32'd0, "relay_channel after reset");
		check_value(32'(front_shift_en), 32'd0, "front_shift_en after reset");
		check_value(32'(front_shift_data), 32'd0, "front_shift_data after reset");
		check_value(32'(front_cs_n), 32'd1, "front_cs_n after reset");
		for (int i = 0; i < NUM_MUX; i++) begin
			check_value(32'(muxsel[i]), 32'd0, $sformatf("muxsel[%0d] after reset", i));
		end
	endtask

	task automatic test_sensor_reads();
		sensor_val_t vals [6];
		reg_data_t expected [12];
		logic [31:0] r;
		for (int s = 0; s < 6; s++) begin
			r = next_random();
			vals[s] = r[31:16];
		end
		for (int i = 0; i < 12; i++) begin
			if (i % 2 == 1) begin
				expected[i] = vals[i/2][15:8];
			end
			else begin
				expected[i] = vals[i/2][7:0];
			end
		end
		@(negedge clk);
		fan0_rpm = vals[0];
		fan1_rpm = vals[1];
		die_temp = vals[2];
		volt_core = vals[3];
		volt_ram = vals[4];
		volt_aux = vals[5];

		// Back-to-back reads, response k lands two falling edges after its drive
		for (int k = 0; k < 15; k++) begin
			@(negedge clk);
			if (k >= 2 && k - 2 < 12) begin
				check_value(32'(rd_valid), 32'd1, $sformatf("sensor read %0d valid", k - 2));
				check_value(32'(rd_data), 32'(expected[k-2]),
					$sformatf("sensor byte at %0h", REG_SENSOR_BASE + reg_addr_t'(k - 2)));
			end
			else begin
				check_value(32'(rd_valid), 32'd0, "rd_valid outside sensor burst");
			end
			rd_en = (k < 12);
			rd_addr = REG_SENSOR_BASE + reg_addr_t'(k);
		end

		read_check(16'h0040, 8'h00, "unmapped 0040");
		read_check(16'h1010, 8'h00, "unmapped 1010");
	endtask

	task automatic test_mux_selectors();
		muxsel_t model [NUM_MUX];
		logic [31:0] r;
		// Upper nibble is junk the register must drop
		for (int i = 0; i < NUM_MUX; i++) begin
			r = next_random();
			model[i] = r[27:24];
			write_reg(REG_MUXSEL_BASE + reg_addr_t'(i), r[31:24]);
		end
		repeat (2) @(negedge clk);
		for (int i = 0; i < NUM_MUX; i++) begin
			check_value(32'(muxsel[i]), 32'(model[i]), $sformatf("muxsel[%0d]", i));
		end

		// Index past the last channel
		write_reg(REG_MUXSEL_BASE + 16'd13, 8'hff);
		repeat (2) @(negedge clk);
		for (int i = 0; i < NUM_MUX; i++) begin
			check_value(32'(muxsel[i]), 32'(model[i]),
				$sformatf("muxsel[%0d] after index 13 write", i));
		end
	endtask

	task automatic relay_command(input relay_chan_t ch, input logic dir);
		write_reg(REG_RELAY_TOGGLE, {6'b0, ch});
		write_reg(REG_RELAY_TOGGLE_1, {dir, 7'b0});
		relay_model[ch] = dir;
		// Strobe still inside the decoder here
		check_value(32'(relay_en), 32'd0, "relay_en before launch");
		@(negedge clk);
		check_value(32'(relay_en), 32'd1, "relay_en pulse");
		check_value(32'(relay_channel), 32'(ch), "relay_channel");
		check_value(32'(relay_dir), 32'(dir), "relay_dir");
		@(negedge clk);
		check_value(32'(relay_en), 32'd0, "relay_en after pulse");

		read_check(REG_RELAY_STAT_1, 8'h01, "relay busy");
		repeat (3) @(negedge clk);
		read_check(REG_RELAY_STAT_1, 8'h01, "relay still busy");
		@(negedge clk);
		relay_done = 1'b1;
		@(negedge clk);
		relay_done = 1'b0;
		read_check(REG_RELAY_STAT_1, 8'h00, "relay idle after done");
	endtask

	task automatic test_relay();
		relay_command(2'd1, 1'b1);
		relay_command(2'd3, 1'b1);
		relay_command(2'd0, 1'b0);
		read_check(REG_RELAY_STAT, 8'h00, "relay stat low byte");
	endtask

	// One shift with the busy flag through to done
	task automatic shift_check(input reg_addr_t addr, input reg_data_t data,
			input reg_data_t expected, input string what);
		write_reg(addr, data);
		check_value(32'(front_shift_en), 32'd0, {what, ": shift_en early"});
		@(negedge clk);
		check_value(32'(front_shift_en), 32'd1, {what, ": shift_en"});
		check_value(32'(front_shift_data), 32'(expected), {what, ": shift byte"});
		@(negedge clk);
		check_value(32'(front_shift_en), 32'd0, {what, ": shift_en after pulse"});
		read_check(REG_FRONT_STAT, 8'h01, {what, ": busy"});
		@(negedge clk);
		front_shift_done = 1'b1;
		@(negedge clk);
		front_shift_done = 1'b0;
		read_check(REG_FRONT_STAT, 8'h00, {what, ": idle"});
	endtask

	task automatic test_front_panel();
		logic [31:0] r;
		led_state_t image;
		write_reg(REG_FRONT_CTRL, 8'h00);
		repeat (2) @(negedge clk);
		check_value(32'(front_cs_n), 32'd0, "front_cs_n cleared");
		write_reg(REG_FRONT_CTRL, 8'h01);
		repeat (2) @(negedge clk);
		check_value(32'(front_cs_n), 32'd1, "front_cs_n set");

		r = next_random();
		shift_check(REG_FRONT_DATA, r[31:24], r[31:24], "data shift");

		// Relay outputs lit so the blanking shows
		r = next_random();
		trig_in_led = r[31:20];
		trig_out_led = r[19:8] | 12'hf00;
		image = panel_image(trig_in_led, trig_out_led, relay_model);
		shift_check(REG_FRONT_LED_0, 8'h5a, image[7:0], "led byte 0");
		shift_check(REG_FRONT_LED_1, 8'h5a, image[15:8], "led byte 1");
		shift_check(REG_FRONT_LED_2, 8'h5a, image[23:16], "led byte 2");
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		rst_n = 1'b0;
		rd_en = 1'b0;
		rd_addr = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		fan0_rpm = '0;
		fan1_rpm = '0;
		die_temp = '0;
		volt_core = '0;
		volt_ram = '0;
		volt_aux = '0;
		trig_in_led = '0;
		trig_out_led = '0;
		relay_done = 1'b0;
		front_shift_done = 1'b0;

		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		test_reset_state();
		test_sensor_reads();
		test_mux_selectors();
		test_relay();
		test_front_panel();

		repeat (2) @(negedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end
		else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/front_panel_ctrl.sv
`timescale 1ns/1ps

module front_panel_ctrl
	import mgmt_pkg::*;
(
	input logic clk,
	input logic rst_n,

	mgmt_bus_if.tgt bus,

	// Indicator sources
	input logic [TRIG_PORTS-1:0] trig_in_led,
	input logic [TRIG_PORTS-1:0] trig_out_led,
	input logic [RELAY_CHANNELS-1:0] relay_state,

	// SPI byte shifter
	input logic front_shift_done,
	output logic front_shift_en,
	output reg_data_t front_shift_data,
	output logic front_cs_n,
	output logic front_busy
);

	// First output port driven through a relay
	localparam int RELAY_PORT_BASE = TRIG_PORTS - RELAY_CHANNELS;

	led_state_t led_image;
	logic cs_wr;
	logic shift_req;
	reg_data_t shift_byte;

	////////////////////////////////////////////////////////////
	// LED image

	always_comb begin
		// Input ports reversed, port 11 lands next to the outputs
		for (int i = 0; i < TRIG_PORTS; i++) begin
			led_image[TRIG_PORTS+i] = trig_in_led[TRIG_PORTS-1-i];
		end
		led_image[TRIG_PORTS-1:0] = trig_out_led;

		// Relay turned to input, so its output indicator stays dark
		for (int k = 0; k < RELAY_CHANNELS; k++) begin
			if (relay_state[k]) begin
				led_image[RELAY_PORT_BASE+k] = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Write decode

	assign cs_wr = bus.wr && bus.blk == BLK_FRONT && bus.offset == REG_FRONT_CTRL[7:0];

	// Raw byte or one slice of the LED image
	always_comb begin
		shift_req = 1'b0;
		shift_byte = bus.wdata;
		if (bus.wr && bus.blk == BLK_FRONT) begin
			case (bus.offset)
				REG_FRONT_DATA[7:0]: shift_req = 1'b1;
				REG_FRONT_LED_0[7:0]: begin
					shift_req = 1'b1;
					shift_byte = led_image[7:0];
				end
				REG_FRONT_LED_1[7:0]: begin
					shift_req = 1'b1;
					shift_byte = led_image[15:8];
				end
				REG_FRONT_LED_2[7:0]: begin
					shift_req = 1'b1;
					shift_byte = led_image[23:16];
				end
				default: shift_req = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			front_shift_en <= 1'b0;
			front_shift_data <= '0;
			front_cs_n <= 1'b1;
			front_busy <= 1'b0;
		end
		else begin
			front_shift_en <= shift_req;
			if (shift_req) begin
				front_shift_data <= shift_byte;
			end
			if (cs_wr) begin
				front_cs_n <= bus.wdata[0];
			end

			// Busy from launch until the shifter reports done
			if (shift_req) begin
				front_busy <= 1'b1;
			end
			else if (front_shift_done) begin
				front_busy <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/mgmt_bus_if.sv
`timescale 1ns/1ps

interface mgmt_bus_if
	import mgmt_pkg::*;
();

	// Single-cycle strobes, never both high
	logic rd;
	logic wr;

	// Decoded target and byte offset inside it
	mgmt_blk_t blk;
	reg_off_t offset;

	// Write byte, only meaningful with wr
	reg_data_t wdata;

	modport dec (
		output rd,
		output wr,
		output blk,
		output offset,
		output wdata
	);

	modport tgt (
		input rd,
		input wr,
		input blk,
		input offset,
		input wdata
	);

endinterface

// File: verilog/mgmt_decode.sv
`timescale 1ns/1ps

module mgmt_decode
	import mgmt_pkg::*;
(
	input logic clk,
	input logic rst_n,

	// Host strobes and addresses
	input logic rd_en,
	input logic wr_en,
	input reg_addr_t rd_addr,
	input reg_addr_t wr_addr,
	input reg_data_t wr_data,

	// Decoded access to the register blocks
	mgmt_bus_if.dec bus
);

	////////////////////////////////////////////////////////////
	// Address classification

	// Address of whichever strobe is active
	reg_addr_t acc_addr;

	assign acc_addr = rd_en ? rd_addr : wr_addr;

	// Map an address onto its block
	function automatic mgmt_blk_t classify(input reg_addr_t addr);
		mgmt_blk_t blk;
		blk = BLK_NONE;
		if (addr >= REG_SENSOR_BASE && addr <= REG_SENSOR_LAST) begin
			blk = BLK_SENSOR;
		end
		else if (addr >= REG_FRONT_CTRL && addr <= REG_FRONT_LED_2) begin
			blk = BLK_FRONT;
		end
		else if (addr >= REG_RELAY_TOGGLE && addr <= REG_RELAY_STAT_1) begin
			blk = BLK_RELAY;
		end
		else if (addr >= REG_MUXSEL_BASE && addr <= REG_MUXSEL_LAST) begin
			blk = BLK_MUX;
		end
		return blk;
	endfunction

	////////////////////////////////////////////////////////////
	// Pipeline register

	// Strobes carry the reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bus.rd <= 1'b0;
			bus.wr <= 1'b0;
		end
		else begin
			bus.rd <= rd_en;
			bus.wr <= wr_en;
		end
	end

	// Target, offset and data ride along with the strobe
	// Blocks only compare the low address byte
	always_ff @(posedge clk) begin
		bus.blk <= classify(acc_addr);
		bus.offset <= acc_addr[7:0];
		bus.wdata <= wr_data;
	end

endmodule

// File: verilog/mgmt_pkg.sv
package mgmt_pkg;

	////////////////////////////////////////////////////////////
	// Widths and counts

	// Trigger ports per direction
	localparam int TRIG_PORTS = 12;

	// Relay channels sit on output ports 8 to 11
	localparam int RELAY_CHANNELS = 4;

	typedef logic [15:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;
	typedef logic [7:0] reg_off_t;
	typedef logic [15:0] sensor_val_t;
	typedef logic [3:0] muxsel_t;
	typedef logic [1:0] relay_chan_t;

	// Input LEDs in the upper half, output LEDs in the lower half
	typedef logic [2*TRIG_PORTS-1:0] led_state_t;

	// Target block of a decoded access
	typedef enum logic [2:0] {
		BLK_NONE,
		BLK_SENSOR,
		BLK_FRONT,
		BLK_RELAY,
		BLK_MUX
	} mgmt_blk_t;

	////////////////////////////////////////////////////////////
	// Register map

	// Six 16-bit sensors, low byte at the even address
	localparam reg_addr_t REG_SENSOR_BASE = 16'h0010;
	localparam reg_addr_t REG_SENSOR_LAST = 16'h001b;

	// Front panel SPI
	localparam reg_addr_t REG_FRONT_CTRL = 16'h0050;
	localparam reg_addr_t REG_FRONT_DATA = 16'h0051;
	localparam reg_addr_t REG_FRONT_STAT = 16'h0052;
	localparam reg_addr_t REG_FRONT_LED_0 = 16'h0053;
	localparam reg_addr_t REG_FRONT_LED_1 = 16'h0054;
	localparam reg_addr_t REG_FRONT_LED_2 = 16'h0055;

	// Relay controller
	localparam reg_addr_t REG_RELAY_TOGGLE = 16'h0070;
	localparam reg_addr_t REG_RELAY_TOGGLE_1 = 16'h0071;
	localparam reg_addr_t REG_RELAY_STAT = 16'h0072;
	localparam reg_addr_t REG_RELAY_STAT_1 = 16'h0073;

	// One selector per channel from here up
	localparam reg_addr_t REG_MUXSEL_BASE = 16'h00f0;
	localparam reg_addr_t REG_MUXSEL_LAST = 16'h00ff;

endpackage

// File: verilog/mgmt_top.sv
`timescale 1ns/1ps

module mgmt_top
	import mgmt_pkg::*;
#(
	parameter int NUM_MUX_CHANNELS = 12
)(
	input logic clk,
	input logic rst_n,

	// Host register bus
	input logic rd_en,
	input reg_addr_t rd_addr,
	output logic rd_valid,
	output reg_data_t rd_data,
	input logic wr_en,
	input reg_addr_t wr_addr,
	input reg_data_t wr_data,

	// Sensors
	input sensor_val_t fan0_rpm,
	input sensor_val_t fan1_rpm,
	input sensor_val_t die_temp,
	input sensor_val_t volt_core,
	input sensor_val_t volt_ram,
	input sensor_val_t volt_aux,

	// Port activity indicators
	input logic [TRIG_PORTS-1:0] trig_in_led,
	input logic [TRIG_PORTS-1:0] trig_out_led,

	// Relay driver
	output logic relay_en,
	output logic relay_dir,
	output relay_chan_t relay_channel,
	input logic relay_done,

	// Front panel SPI
	output logic front_shift_en,
	output reg_data_t front_shift_data,
	input logic front_shift_done,
	output logic front_cs_n,

	// Crossbar selectors
	output muxsel_t [NUM_MUX_CHANNELS-1:0] muxsel
);

	logic [RELAY_CHANNELS-1:0] relay_state;
	logic relay_busy;
	logic front_busy;

	mgmt_bus_if bus();

	////////////////////////////////////////////////////////////
	// Decode, register blocks, read return

	mgmt_decode i_decode (
		.clk(clk),
		.rst_n(rst_n),
		.rd_en(rd_en),
		.wr_en(wr_en),
		.rd_addr(rd_addr),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.bus(bus.dec)
	);

	relay_ctrl i_relay (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus.tgt),
		.relay_done(relay_done),
		.relay_en(relay_en),
		.relay_dir(relay_dir),
		.relay_channel(relay_channel),
		.relay_state(relay_state),
		.relay_busy(relay_busy)
	);

	front_panel_ctrl i_front (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus.tgt),
		.trig_in_led(trig_in_led),
		.trig_out_led(trig_out_led),
		.relay_state(relay_state),
		.front_shift_done(front_shift_done),
		.front_shift_en(front_shift_en),
		.front_shift_data(front_shift_data),
		.front_cs_n(front_cs_n),
		.front_busy(front_busy)
	);

	muxsel_regs #(
		.NUM_MUX_CHANNELS(NUM_MUX_CHANNELS)
	) i_muxsel (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus.tgt),
		.muxsel(muxsel)
	);

	read_return i_read (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus.tgt),
		.fan0_rpm(fan0_rpm),
		.fan1_rpm(fan1_rpm),
		.die_temp(die_temp),
		.volt_core(volt_core),
		.volt_ram(volt_ram),
		.volt_aux(volt_aux),
		.relay_busy(relay_busy),
		.front_busy(front_busy),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

endmodule

// File: verilog/muxsel_regs.sv
`timescale 1ns/1ps

module muxsel_regs
	import mgmt_pkg::*;
#(
	parameter int NUM_MUX_CHANNELS = 12
)(
	input logic clk,
	input logic rst_n,

	mgmt_bus_if.tgt bus,

	// One input selector per crossbar channel
	output muxsel_t [NUM_MUX_CHANNELS-1:0] muxsel
);

	// Channel index from the low offset nibble
	logic [3:0] sel_idx;
	logic sel_wr;

	assign sel_idx = bus.offset[3:0];

	// Indices past the last channel fall away
	assign sel_wr = bus.wr && bus.blk == BLK_MUX && int'(sel_idx) < NUM_MUX_CHANNELS;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			muxsel <= '0;
		end
		else if (sel_wr) begin
			muxsel[sel_idx] <= bus.wdata[3:0];
		end
	end

endmodule

// File: verilog/read_return.sv
`timescale 1ns/1ps

module read_return
	import mgmt_pkg::*;
(
	input logic clk,
	input logic rst_n,

	mgmt_bus_if.tgt bus,

	// Sensor readings
	input sensor_val_t fan0_rpm,
	input sensor_val_t fan1_rpm,
	input sensor_val_t die_temp,
	input sensor_val_t volt_core,
	input sensor_val_t volt_ram,
	input sensor_val_t volt_aux,

	// Block status
	input logic relay_busy,
	input logic front_busy,

	// Read response to the host
	output logic rd_valid,
	output reg_data_t rd_data
);

	reg_off_t sensor_rel;
	sensor_val_t sensor_val;
	reg_data_t rd_byte;

	////////////////////////////////////////////////////////////
	// Sensor select

	// Two bytes per sensor
	assign sensor_rel = bus.offset - REG_SENSOR_BASE[7:0];

	always_comb begin
		case (sensor_rel[3:1])
			3'd0: sensor_val = fan0_rpm;
			3'd1: sensor_val = fan1_rpm;
			3'd2: sensor_val = die_temp;
			3'd3: sensor_val = volt_core;
			3'd4: sensor_val = volt_ram;
			3'd5: sensor_val = volt_aux;
			default: sensor_val = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Read byte mux

	always_comb begin
		rd_byte = '0;
		case (bus.blk)
			// Even offset gives the low byte
			BLK_SENSOR: rd_byte = sensor_rel[0] ? sensor_val[15:8] : sensor_val[7:0];
			BLK_FRONT: begin
				if (bus.offset == REG_FRONT_STAT[7:0]) begin
					rd_byte = {7'b0, front_busy};
				end
			end
			// Low status byte stays zero
			BLK_RELAY: begin
				if (bus.offset == REG_RELAY_STAT_1[7:0]) begin
					rd_byte = {7'b0, relay_busy};
				end
			end
			// Write-only and unmapped registers
			default: rd_byte = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
			rd_data <= '0;
		end
		else begin
			rd_valid <= bus.rd;
			if (bus.rd) begin
				rd_data <= rd_byte;
			end
		end
	end

endmodule

// File: verilog/relay_ctrl.sv
`timescale 1ns/1ps

module relay_ctrl
	import mgmt_pkg::*;
(
	input logic clk,
	input logic rst_n,

	mgmt_bus_if.tgt bus,

	// Relay driver handshake
	input logic relay_done,
	output logic relay_en,
	output logic relay_dir,
	output relay_chan_t relay_channel,

	// Direction per channel, 1 = input
	output logic [RELAY_CHANNELS-1:0] relay_state,
	output logic relay_busy
);

	// Channel select write
	logic chan_wr;
	// Direction write, launches the toggle
	logic launch;

	assign chan_wr = bus.wr && bus.blk == BLK_RELAY && bus.offset == REG_RELAY_TOGGLE[7:0];
	assign launch = bus.wr && bus.blk == BLK_RELAY && bus.offset == REG_RELAY_TOGGLE_1[7:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			relay_en <= 1'b0;
			relay_dir <= 1'b0;
			relay_channel <= '0;
			relay_state <= '0;
			relay_busy <= 1'b0;
		end
		else begin
			// One-cycle command pulse
			relay_en <= launch;

			if (chan_wr) begin
				relay_channel <= bus.wdata[1:0];
			end

			// Record direction at launch, against the latched channel
			if (launch) begin
				relay_dir <= bus.wdata[7];
				relay_state[relay_channel] <= bus.wdata[7];
			end

			// Launch wins over a done in the same cycle
			if (launch) begin
				relay_busy <= 1'b1;
			end
			else if (relay_done) begin
				relay_busy <= 1'b0;
			end
		end
	end

endmodule
